// ==== verilog.f ====
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/mem_port_if.sv
logic/unified_ram.sv
logic/mem_arbiter.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/flop_id2ex.sv
logic/execute_stage.sv
logic/cpu_top.sv
tests/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/cpu_tb.sv ====
`default_nettype none

module cpu_tb
    import isa_pkg::*, pipe_pkg::*;
();
    localparam int ADDR_BITS    = 8;
    localparam int RUN_LIMIT    = 4000;
    localparam int TAIL_CYCLES  = 12;
    localparam int RANDOM_COUNT = 20;

    // one program word with the writeback it should produce
    typedef struct packed {
        word_t    instr;
        logic     wb;
        reg_idx_t rd;
        word_t    val;
    } row_t;

    logic                 clk;
    logic                 i_reset;
    logic                 i_run;
    logic                 i_load_en;
    logic [ADDR_BITS-1:0] i_load_addr;
    word_t                i_load_data;
    logic                 o_wb_valid;
    reg_idx_t             o_wb_reg;
    word_t                o_wb_data;
    logic                 o_halt;

    row_t        rows [$];
    int          prog_start [$];
    row_t        expect_q [$];
    logic [31:0] rng_state;

    cpu_top #(.ADDR_BITS(ADDR_BITS)) cpu_top_i (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_run       (i_run),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .o_wb_valid  (o_wb_valid),
        .o_wb_reg    (o_wb_reg),
        .o_wb_data   (o_wb_data),
        .o_halt      (o_halt)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic word_t sign_extend6(logic [5:0] imm);
        return {{10{imm[5]}}, imm};
    endfunction

    function automatic word_t encode_reg(logic [2:0] func, reg_idx_t ro, reg_idx_t rx,
                                         reg_idx_t ry);
        instr_t w;
        w.reg_fmt.opcode = OP_ALU;
        w.reg_fmt.rO     = ro;
        w.reg_fmt.rX     = rx;
        w.reg_fmt.rY     = ry;
        w.reg_fmt.func   = func;
        return w;
    endfunction

    function automatic word_t encode_imm(opcode_t op, logic [2:0] ro, reg_idx_t rx,
                                         logic [5:0] imm);
        instr_t w;
        w.imm_fmt.opcode = op;
        w.imm_fmt.rO     = ro;
        w.imm_fmt.rX     = rx;
        w.imm_fmt.imm6   = imm;
        return w;
    endfunction

    // reference ALU where func 0..7 is add, sub, and, or, xor, shl, shr and signed slt
    function automatic word_t alu_model(logic [2:0] func, word_t a, word_t b);
        word_t r;
        case (func)
            3'd0: r = a + b;
            3'd1: r = a - b;
            3'd2: r = a & b;
            3'd3: r = a | b;
            3'd4: r = a ^ b;
            3'd5: r = a << b[3:0];
            3'd6: r = a >> b[3:0];
            default: r = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
        endcase
        return r;
    endfunction

    task automatic fail_now(string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic add_row(word_t instr, logic wb, reg_idx_t rd, word_t val);
        row_t r;
        r.instr = instr;
        r.wb    = wb;
        r.rd    = rd;
        r.val   = val;
        rows.push_back(r);
    endtask

    task automatic begin_program();
        prog_start.push_back(rows.size());
    endtask

    // every program opens with xor r0,r0,r0 to get a known zero
    task automatic build_directed();
        begin_program();
        add_row(encode_reg(3'd4, 3'd0, 3'd0, 3'd0), 1'b1, 3'd0, 16'h0000);
        add_row(encode_imm(OP_ADDI, 3'd1, 3'd0, 6'd5), 1'b1, 3'd1, 16'h0005);
        add_row(encode_imm(OP_ADDI, 3'd2, 3'd0, 6'h3d), 1'b1, 3'd2, 16'hfffd);
        add_row(encode_imm(OP_ADDI, 3'd3, 3'd0, 6'h1f), 1'b1, 3'd3, 16'h001f);
        add_row(encode_imm(OP_ADDI, 3'd4, 3'd0, 6'h20), 1'b1, 3'd4, 16'hffe0);
        add_row(encode_imm(OP_HALT, 3'd0, 3'd0, 6'd0), 1'b0, 3'd0, 16'h0000);

        begin_program();
        add_row(encode_reg(3'd4, 3'd0, 3'd0, 3'd0), 1'b1, 3'd0, 16'h0000);
        add_row(encode_imm(OP_ADDI, 3'd1, 3'd0, 6'd12), 1'b1, 3'd1, 16'h000c);
        add_row(encode_imm(OP_ADDI, 3'd2, 3'd0, 6'h3a), 1'b1, 3'd2, 16'hfffa);
        add_row(encode_reg(3'd0, 3'd3, 3'd1, 3'd2), 1'b1, 3'd3, 16'h0006);
        add_row(encode_reg(3'd1, 3'd4, 3'd1, 3'd2), 1'b1, 3'd4, 16'h0012);
        add_row(encode_reg(3'd2, 3'd5, 3'd1, 3'd2), 1'b1, 3'd5, 16'h0008);
        add_row(encode_reg(3'd3, 3'd6, 3'd1, 3'd2), 1'b1, 3'd6, 16'hfffe);
        add_row(encode_reg(3'd4, 3'd7, 3'd1, 3'd2), 1'b1, 3'd7, 16'hfff6);
        add_row(encode_imm(OP_ADDI, 3'd3, 3'd0, 6'd3), 1'b1, 3'd3, 16'h0003);
        add_row(encode_reg(3'd5, 3'd4, 3'd1, 3'd3), 1'b1, 3'd4, 16'h0060);
        add_row(encode_reg(3'd6, 3'd5, 3'd2, 3'd3), 1'b1, 3'd5, 16'h1fff);
        add_row(encode_reg(3'd7, 3'd6, 3'd2, 3'd1), 1'b1, 3'd6, 16'h0001);
        add_row(encode_reg(3'd7, 3'd7, 3'd1, 3'd2), 1'b1, 3'd7, 16'h0000);
        add_row(encode_reg(3'd0, 3'd1, 3'd1, 3'd1), 1'b1, 3'd1, 16'h0018);
        add_row(encode_reg(3'd0, 3'd1, 3'd1, 3'd1), 1'b1, 3'd1, 16'h0030);
        add_row(encode_imm(OP_HALT, 3'd0, 3'd0, 6'd0), 1'b0, 3'd0, 16'h0000);

        // store then load with data at 25 and 19
        begin_program();
        add_row(encode_reg(3'd4, 3'd0, 3'd0, 3'd0), 1'b1, 3'd0, 16'h0000);
        add_row(encode_imm(OP_ADDI, 3'd1, 3'd0, 6'd20), 1'b1, 3'd1, 16'h0014);
        add_row(encode_imm(OP_ADDI, 3'd2, 3'd0, 6'h2f), 1'b1, 3'd2, 16'hffef);
        add_row(encode_imm(OP_SW, 3'd2, 3'd1, 6'd5), 1'b0, 3'd0, 16'h0000);
        add_row(encode_imm(OP_LW, 3'd3, 3'd1, 6'd5), 1'b1, 3'd3, 16'hffef);
        add_row(encode_imm(OP_ADDI, 3'd4, 3'd3, 6'd1), 1'b1, 3'd4, 16'hfff0);
        add_row(encode_imm(OP_SW, 3'd4, 3'd1, 6'h3f), 1'b0, 3'd0, 16'h0000);
        add_row(encode_imm(OP_LW, 3'd5, 3'd1, 6'h3f), 1'b1, 3'd5, 16'hfff0);
        add_row(encode_imm(OP_HALT, 3'd0, 3'd0, 6'd0), 1'b0, 3'd0, 16'h0000);

        // branch offsets are relative to pc plus one
        begin_program();
        add_row(encode_reg(3'd4, 3'd0, 3'd0, 3'd0), 1'b1, 3'd0, 16'h0000);
        add_row(encode_imm(OP_BR, FCU_ALWAYS, 3'd0, 6'd1), 1'b0, 3'd0, 16'h0000);
        add_row(encode_imm(OP_ADDI, 3'd1, 3'd0, 6'd1), 1'b0, 3'd0, 16'h0000);
        add_row(encode_imm(OP_ADDI, 3'd2, 3'd0, 6'd0), 1'b1, 3'd2, 16'h0000);
        add_row(encode_imm(OP_BR, FCU_ZERO, 3'd0, 6'd1), 1'b0, 3'd0, 16'h0000);
        add_row(encode_imm(OP_ADDI, 3'd3, 3'd0, 6'd7), 1'b0, 3'd0, 16'h0000);
        add_row(encode_imm(OP_BR, FCU_NONZERO, 3'd0, 6'd1), 1'b0, 3'd0, 16'h0000);
        add_row(encode_imm(OP_ADDI, 3'd4, 3'd0, 6'd2), 1'b1, 3'd4, 16'h0002);
        add_row(encode_imm(OP_BR, FCU_ZERO, 3'd0, 6'd1), 1'b0, 3'd0, 16'h0000);
        add_row(encode_imm(OP_ADDI, 3'd5, 3'd0, 6'd3), 1'b1, 3'd5, 16'h0003);
        add_row(encode_imm(OP_BR, FCU_NONZERO, 3'd0, 6'd1), 1'b0, 3'd0, 16'h0000);
        add_row(encode_imm(OP_ADDI, 3'd6, 3'd0, 6'd9), 1'b0, 3'd0, 16'h0000);
        add_row(encode_imm(OP_ADDI, 3'd7, 3'd0, 6'd15), 1'b1, 3'd7, 16'h000f);
        add_row(encode_imm(OP_JR, 3'd0, 3'd7, 6'd0), 1'b0, 3'd0, 16'h0000);
        add_row(encode_imm(OP_ADDI, 3'd1, 3'd0, 6'd4), 1'b0, 3'd0, 16'h0000);
        add_row(encode_imm(OP_ADDI, 3'd1, 3'd0, 6'h3f), 1'b1, 3'd1, 16'hffff);
        add_row(encode_imm(OP_HALT, 3'd0, 3'd0, 6'd0), 1'b0, 3'd0, 16'h0000);
        add_row(encode_imm(OP_ADDI, 3'd2, 3'd0, 6'd1), 1'b0, 3'd0, 16'h0000);
    endtask

    task automatic build_random(int count);
        word_t       model [8];
        logic [31:0] x;
        reg_idx_t    ro;
        reg_idx_t    rx;
        reg_idx_t    ry;
        logic [2:0]  func;
        logic [5:0]  imm;
        begin_program();
        add_row(encode_reg(3'd4, 3'd0, 3'd0, 3'd0), 1'b1, 3'd0, 16'h0000);
        model[0] = '0;
        for (int r = 1; r < 8; r++) begin
            x = xorshift32();
            imm = x[5:0];
            model[r] = sign_extend6(imm);
            add_row(encode_imm(OP_ADDI, reg_idx_t'(r), 3'd0, imm), 1'b1, reg_idx_t'(r),
                    model[r]);
        end
        for (int i = 0; i < count; i++) begin
            x = xorshift32();
            ro = x[2:0];
            rx = x[5:3];
            ry = x[8:6];
            func = x[11:9];
            imm = x[17:12];
            if (x[20]) begin
                model[ro] = alu_model(func, model[rx], model[ry]);
                add_row(encode_reg(func, ro, rx, ry), 1'b1, ro, model[ro]);
            end else begin
                model[ro] = model[rx] + sign_extend6(imm);
                add_row(encode_imm(OP_ADDI, ro, rx, imm), 1'b1, ro, model[ro]);
            end
        end
        add_row(encode_imm(OP_HALT, 3'd0, 3'd0, 6'd0), 1'b0, 3'd0, 16'h0000);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        i_reset <= 1'b1;
        i_run   <= 1'b0;
        repeat (5) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        check_bit("o_wb_valid", o_wb_valid, 1'b0);
        check_bit("o_halt", o_halt, 1'b0);
    endtask

    task automatic load_program(int first, int last);
        for (int i = first; i <= last; i++) begin
            @(posedge clk);
            i_load_en   <= 1'b1;
            i_load_addr <= ADDR_BITS'(i - first);
            i_load_data <= rows[i].instr;
            if (rows[i].wb) begin
                expect_q.push_back(rows[i]);
            end
        end
        @(posedge clk);
        i_load_en <= 1'b0;
    endtask

    // writebacks must arrive in program order
    task automatic observe_writeback();
        row_t e;
        if (o_wb_valid) begin
            if (expect_q.size() == 0) begin
                fail_now("a writeback arrived when none was expected");
            end else begin
                e = expect_q.pop_front();
                check_reg("o_wb_reg", o_wb_reg, e.rd);
                check_word("o_wb_data", o_wb_data, e.val);
            end
        end
    endtask

    task automatic run_program(int first, int last);
        int   cycles;
        logic done;
        expect_q.delete();
        apply_reset();
        load_program(first, last);
        @(posedge clk);
        i_run <= 1'b1;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < RUN_LIMIT) begin
            @(negedge clk);
            observe_writeback();
            done = o_halt;
            cycles++;
        end
        if (!done) begin
            fail_now("timed out waiting for o_halt");
        end else if (expect_q.size() != 0) begin
            fail_now($sformatf("halted with %0d writebacks still missing", expect_q.size()));
        end
        // halt must stick with nothing written after it
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            check_bit("o_halt", o_halt, 1'b1);
            check_bit("o_wb_valid", o_wb_valid, 1'b0);
        end
        @(posedge clk);
        i_run <= 1'b0;
    endtask

    initial begin
        int last;
        clk         = 1'b0;
        i_reset     = 1'b1;
        i_run       = 1'b0;
        i_load_en   = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        rng_state   = 32'h83c78340;
        build_directed();
        build_random(RANDOM_COUNT);
        for (int p = 0; p < prog_start.size(); p++) begin
            if (p + 1 < prog_start.size()) begin
                last = prog_start[p + 1] - 1;
            end else begin
                last = rows.size() - 1;
            end
            run_program(prog_start[p], last);
        end
        $display("All tests passed");
        $finish;
    end
endmodule

`default_nettype wire

// ==== logic/cpu_top.sv ====
`default_nettype none

module cpu_top import isa_pkg::*, pipe_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  wire                 clk,
    input  wire                 i_reset,
    input  wire                 i_run,
    input  wire                 i_load_en,
    input  wire [ADDR_BITS-1:0] i_load_addr,
    input  wire word_t          i_load_data,
    output logic                o_wb_valid,
    output reg_idx_t            o_wb_reg,
    output word_t               o_wb_data,
    output logic                o_halt
);
    mem_port_if #(.ADDR_BITS(ADDR_BITS)) load_if ();
    mem_port_if #(.ADDR_BITS(ADDR_BITS)) data_if ();
    mem_port_if #(.ADDR_BITS(ADDR_BITS)) fetch_if ();

    instr_t               f2d_instr;
    word_t                f2d_pc;
    logic                 f2d_valid;
    logic                 stall;
    logic                 bubble;
    id_ex_t               id_ex_d;
    id_ex_t               id_ex_q;
    logic                 redirect;
    logic [ADDR_BITS-1:0] target;
    logic                 ram_we;
    logic [ADDR_BITS-1:0] ram_addr;
    word_t                ram_wdata;
    word_t                ram_rdata;

    // the program loader only ever writes
    assign load_if.req   = i_load_en;
    assign load_if.we    = 1'b1;
    assign load_if.addr  = i_load_addr;
    assign load_if.wdata = i_load_data;

    fetch_unit #(.ADDR_BITS(ADDR_BITS)) fetch_unit_i (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_run      (i_run),
        .i_stall    (stall),
        .i_redirect (redirect),
        .i_target   (target),
        .mem        (fetch_if.requester),
        .o_instr    (f2d_instr),
        .o_pc       (f2d_pc),
        .o_valid    (f2d_valid)
    );

    decode_stage decode_stage_i (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_instr    (f2d_instr),
        .i_pc       (f2d_pc),
        .i_valid    (f2d_valid),
        .i_squash   (redirect),
        .i_wb_valid (o_wb_valid),
        .i_wb_reg   (o_wb_reg),
        .i_wb_data  (o_wb_data),
        .o_stall    (stall),
        .o_bubble   (bubble),
        .o_id_ex    (id_ex_d)
    );

    flop_id2ex flop_id2ex_i (
        .clk      (clk),
        .rst      (i_reset),
        .i_bubble (bubble),
        .i_id_ex  (id_ex_d),
        .o_id_ex  (id_ex_q)
    );

    execute_stage #(.ADDR_BITS(ADDR_BITS)) execute_stage_i (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_id_ex    (id_ex_q),
        .mem        (data_if.requester),
        .o_redirect (redirect),
        .o_target   (target),
        .o_wb_valid (o_wb_valid),
        .o_wb_reg   (o_wb_reg),
        .o_wb_data  (o_wb_data),
        .o_halt     (o_halt)
    );

    mem_arbiter #(.ADDR_BITS(ADDR_BITS)) mem_arbiter_i (
        .clk         (clk),
        .i_reset     (i_reset),
        .load_port   (load_if.arbiter),
        .data_port   (data_if.arbiter),
        .fetch_port  (fetch_if.arbiter),
        .o_ram_we    (ram_we),
        .o_ram_addr  (ram_addr),
        .o_ram_wdata (ram_wdata),
        .i_ram_rdata (ram_rdata)
    );

    unified_ram #(.ADDR_BITS(ADDR_BITS)) unified_ram_i (
        .clk     (clk),
        .i_we    (ram_we),
        .i_addr  (ram_addr),
        .i_wdata (ram_wdata),
        .o_rdata (ram_rdata)
    );
endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`default_nettype none

module execute_stage import isa_pkg::*, pipe_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  wire                  clk,
    input  wire                  i_reset,
    input  wire id_ex_t          i_id_ex,
    mem_port_if.requester        mem,
    output logic                 o_redirect,
    output logic [ADDR_BITS-1:0] o_target,
    output logic                 o_wb_valid,
    output reg_idx_t             o_wb_reg,
    output word_t                o_wb_data,
    output logic                 o_halt
);
    word_t alu_b;
    word_t alu_res;
    word_t alu_q;
    logic  zero_q;
    logic  cond_ok;
    logic  wb_mem_q;

    assign alu_b = i_id_ex.alu_b_imm ? i_id_ex.imm16 : i_id_ex.vY;

    always_comb begin
        case (i_id_ex.alu_op)
            ADD:     alu_res = i_id_ex.vX + alu_b;
            SUB:     alu_res = i_id_ex.vX - alu_b;
            AND:     alu_res = i_id_ex.vX & alu_b;
            OR:      alu_res = i_id_ex.vX | alu_b;
            XOR:     alu_res = i_id_ex.vX ^ alu_b;
            SHL:     alu_res = i_id_ex.vX << alu_b[3:0];
            SHR:     alu_res = i_id_ex.vX >> alu_b[3:0];
            SLT:     alu_res = {15'd0, $signed(i_id_ex.vX) < $signed(alu_b)};
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        case (i_id_ex.fcu_op)
            FCU_ALWAYS:  cond_ok = 1'b1;
            FCU_ZERO:    cond_ok = zero_q;
            FCU_NONZERO: cond_ok = ~zero_q;
            default:     cond_ok = 1'b0;
        endcase
        case (i_id_ex.flow_ty)
            FLOW_BRANCH:  o_redirect = cond_ok & ~o_halt;
            FLOW_JUMPREG: o_redirect = ~o_halt;
            default:      o_redirect = 1'b0;
        endcase
        if (i_id_ex.flow_ty == FLOW_JUMPREG) begin
            o_target = i_id_ex.vX[ADDR_BITS-1:0];
        end else begin
            o_target = i_id_ex.imm16[ADDR_BITS-1:0];
        end
    end

    // address is vX plus imm16, which the ALU already forms for LW and SW
    assign mem.req   = (i_id_ex.dmem_ren | i_id_ex.dmem_wen) & ~o_halt;
    assign mem.we    = i_id_ex.dmem_wen;
    assign mem.addr  = alu_res[ADDR_BITS-1:0];
    assign mem.wdata = i_id_ex.vY;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_wb_valid <= 1'b0;
            o_halt     <= 1'b0;
            zero_q     <= 1'b0;
        end else begin
            o_wb_valid <= i_id_ex.rf_wen & ~o_halt;
            if (i_id_ex.halt) begin
                o_halt <= 1'b1;
            end
            if (i_id_ex.writeflag && !o_halt) begin
                zero_q <= (alu_res == '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        o_wb_reg <= i_id_ex.rO;
        alu_q    <= alu_res;
        wb_mem_q <= (i_id_ex.wb_op == WB_MEM);
    end

    // load data arrives from the RAM in the writeback cycle
    assign o_wb_data = wb_mem_q ? mem.rdata : alu_q;
endmodule

`default_nettype wire

// ==== logic/flop_id2ex.sv ====
`default_nettype none

module flop_id2ex import isa_pkg::*, pipe_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         i_bubble,
    input  wire id_ex_t i_id_ex,
    output id_ex_t      o_id_ex
);
    always_ff @(posedge clk) begin
        o_id_ex <= i_id_ex;
        // a bubble keeps the payload but loses every side effect
        o_id_ex.halt      <= i_id_ex.halt & ~i_bubble;
        o_id_ex.rf_wen    <= i_id_ex.rf_wen & ~i_bubble;
        o_id_ex.writeflag <= i_id_ex.writeflag & ~i_bubble;
        o_id_ex.dmem_ren  <= i_id_ex.dmem_ren & ~i_bubble;
        o_id_ex.dmem_wen  <= i_id_ex.dmem_wen & ~i_bubble;
        o_id_ex.flow_ty   <= i_bubble ? FLOW_BASIC : i_id_ex.flow_ty;
        if (rst) begin
            o_id_ex.halt      <= 1'b0;
            o_id_ex.rf_wen    <= 1'b0;
            o_id_ex.writeflag <= 1'b0;
            o_id_ex.dmem_ren  <= 1'b0;
            o_id_ex.dmem_wen  <= 1'b0;
            o_id_ex.flow_ty   <= FLOW_BASIC;
        end
    end
endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`default_nettype none

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  wire           clk,
    input  wire           i_reset,
    input  wire instr_t   i_instr,
    input  wire word_t    i_pc,
    input  wire           i_valid,
    input  wire           i_squash,
    input  wire           i_wb_valid,
    input  wire reg_idx_t i_wb_reg,
    input  wire word_t    i_wb_data,
    output logic          o_stall,
    output logic          o_bubble,
    output id_ex_t        o_id_ex
);
    word_t      regs [8];
    logic [7:0] pending_q;
    opcode_t    op;
    word_t      imm_sext;
    logic       uses_x;
    logic       uses_y;

    assign op       = i_instr.reg_fmt.opcode;
    assign imm_sext = {{10{i_instr.imm_fmt.imm6[5]}}, i_instr.imm_fmt.imm6};

    always_comb begin
        o_id_ex           = '0;
        o_id_ex.rO        = i_instr.imm_fmt.rO;
        o_id_ex.rX        = i_instr.imm_fmt.rX;
        o_id_ex.alu_op    = ADD;
        o_id_ex.alu_b_imm = 1'b1;
        o_id_ex.imm16     = imm_sext;
        uses_x            = 1'b0;
        uses_y            = 1'b0;
        case (op)
            OP_ALU: begin
                o_id_ex.rY        = i_instr.reg_fmt.rY;
                o_id_ex.alu_op    = alu_op_t'({1'b0, i_instr.reg_fmt.func});
                o_id_ex.alu_b_imm = 1'b0;
                o_id_ex.rf_wen    = 1'b1;
                o_id_ex.writeflag = 1'b1;
                uses_x            = 1'b1;
                uses_y            = 1'b1;
            end
            OP_ADDI: begin
                o_id_ex.rf_wen    = 1'b1;
                o_id_ex.writeflag = 1'b1;
                uses_x            = 1'b1;
            end
            OP_LW: begin
                o_id_ex.rf_wen   = 1'b1;
                o_id_ex.wb_op    = WB_MEM;
                o_id_ex.dmem_ren = 1'b1;
                uses_x           = 1'b1;
            end
            OP_SW: begin
                // store data comes from rO through the vY read port
                o_id_ex.rY       = i_instr.imm_fmt.rO;
                o_id_ex.dmem_wen = 1'b1;
                uses_x           = 1'b1;
                uses_y           = 1'b1;
            end
            OP_BR: begin
                o_id_ex.fcu_op  = fcu_op_t'(i_instr.imm_fmt.rO);
                o_id_ex.flow_ty = FLOW_BRANCH;
                o_id_ex.imm16   = i_pc + 16'd1 + imm_sext;
            end
            OP_JR: begin
                o_id_ex.flow_ty = FLOW_JUMPREG;
                uses_x          = 1'b1;
            end
            OP_HALT: begin
                o_id_ex.halt = 1'b1;
            end
            default: begin
            end
        endcase
        o_id_ex.vX = regs[o_id_ex.rX];
        o_id_ex.vY = regs[o_id_ex.rY];
    end

    // hold on any pending source, and on a pending destination to keep writes ordered
    always_comb begin
        o_stall = i_valid & ~i_squash
            & ((uses_x & pending_q[o_id_ex.rX])
            | (uses_y & pending_q[o_id_ex.rY])
            | (o_id_ex.rf_wen & pending_q[o_id_ex.rO]));
        o_bubble = ~i_valid | i_squash | o_stall;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pending_q <= 8'h00;
        end else begin
            if (i_wb_valid) begin
                pending_q[i_wb_reg] <= 1'b0;
            end
            if (!o_bubble && o_id_ex.rf_wen) begin
                pending_q[o_id_ex.rO] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_wb_valid) begin
            regs[i_wb_reg] <= i_wb_data;
        end
    end
endmodule

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`default_nettype none

module fetch_unit import isa_pkg::*, pipe_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  wire                 clk,
    input  wire                 i_reset,
    input  wire                 i_run,
    input  wire                 i_stall,
    input  wire                 i_redirect,
    input  wire [ADDR_BITS-1:0] i_target,
    mem_port_if.requester       mem,
    output instr_t              o_instr,
    output word_t               o_pc,
    output logic                o_valid
);
    logic [ADDR_BITS-1:0] pc_q;
    logic                 pending_q;
    logic                 halted_q;
    logic                 take;
    instr_t               rd_instr;

    // one request at a time, and only when the instruction register frees up
    assign mem.req   = i_run & ~halted_q & ~pending_q & ~i_redirect & (~o_valid | ~i_stall);
    assign mem.we    = 1'b0;
    assign mem.addr  = pc_q;
    assign mem.wdata = '0;

    // a reply landing with a redirect belongs to the wrong path
    assign take     = mem.rvalid & ~i_redirect;
    assign rd_instr = mem.rdata;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc_q      <= '0;
            pending_q <= 1'b0;
            halted_q  <= 1'b0;
            o_valid   <= 1'b0;
        end else begin
            pending_q <= mem.req & mem.gnt;
            if (i_redirect) begin
                pc_q <= i_target;
            end else if (mem.req && mem.gnt) begin
                pc_q <= pc_q + 1'b1;
            end
            // nothing past a halt is fetched unless a branch steers away
            if (i_redirect) begin
                halted_q <= 1'b0;
            end else if (take && rd_instr.reg_fmt.opcode == OP_HALT) begin
                halted_q <= 1'b1;
            end
            if (take) begin
                o_valid <= 1'b1;
            end else if (i_redirect || !i_stall) begin
                o_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            o_instr <= rd_instr;
            o_pc    <= word_t'(pc_q - 1'b1);
        end
    end
endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter import pipe_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  wire                  clk,
    input  wire                  i_reset,
    mem_port_if.arbiter          load_port,
    mem_port_if.arbiter          data_port,
    mem_port_if.arbiter          fetch_port,
    output logic                 o_ram_we,
    output logic [ADDR_BITS-1:0] o_ram_addr,
    output word_t                o_ram_wdata,
    input  wire word_t           i_ram_rdata
);
    // which port owns the read coming back this cycle: {load, data, fetch}
    logic [2:0] rd_owner_q;

    always_comb begin
        load_port.gnt  = load_port.req;
        data_port.gnt  = data_port.req & ~load_port.req;
        fetch_port.gnt = fetch_port.req & ~load_port.req & ~data_port.req;
    end

    always_comb begin
        o_ram_we    = fetch_port.req & fetch_port.we;
        o_ram_addr  = fetch_port.addr;
        o_ram_wdata = fetch_port.wdata;
        if (load_port.req) begin
            o_ram_we    = load_port.we;
            o_ram_addr  = load_port.addr;
            o_ram_wdata = load_port.wdata;
        end else if (data_port.req) begin
            o_ram_we    = data_port.we;
            o_ram_addr  = data_port.addr;
            o_ram_wdata = data_port.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            rd_owner_q <= 3'b000;
        end else begin
            rd_owner_q[2] <= load_port.gnt & ~load_port.we;
            rd_owner_q[1] <= data_port.gnt & ~data_port.we;
            rd_owner_q[0] <= fetch_port.gnt & ~fetch_port.we;
        end
    end

    assign load_port.rvalid  = rd_owner_q[2];
    assign data_port.rvalid  = rd_owner_q[1];
    assign fetch_port.rvalid = rd_owner_q[0];
    assign load_port.rdata   = rd_owner_q[2] ? i_ram_rdata : '0;
    assign data_port.rdata   = rd_owner_q[1] ? i_ram_rdata : '0;
    assign fetch_port.rdata  = rd_owner_q[0] ? i_ram_rdata : '0;
endmodule

`default_nettype wire

// ==== logic/unified_ram.sv ====
`default_nettype none

module unified_ram import pipe_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  wire                 clk,
    input  wire                 i_we,
    input  wire [ADDR_BITS-1:0] i_addr,
    input  wire word_t          i_wdata,
    output word_t               o_rdata
);
    // program and data share this array
    word_t mem [2**ADDR_BITS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];
    end
endmodule

`default_nettype wire

// ==== logic/mem_port_if.sv ====
`default_nettype none

interface mem_port_if import pipe_pkg::*; #(
    parameter int ADDR_BITS = 8
);
    logic                 req;
    logic                 we;
    logic [ADDR_BITS-1:0] addr;
    word_t                wdata;
    logic                 gnt;
    logic                 rvalid;
    word_t                rdata;

    modport requester (output req, we, addr, wdata, input gnt, rvalid, rdata);
    modport arbiter (input req, we, addr, wdata, output gnt, rvalid, rdata);
endinterface

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  reg_idx_t;

    // encoding matches the func field of OP_ALU
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SHL = 4'd5,
        SHR = 4'd6,
        SLT = 4'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1
    } wb_op_t;

    typedef struct packed {
        logic               halt;
        alu_op_t            alu_op;
        logic               alu_b_imm;
        isa_pkg::fcu_op_t   fcu_op;
        isa_pkg::flow_ty_t  flow_ty;
        logic               rf_wen;
        wb_op_t             wb_op;
        logic               writeflag;
        logic               dmem_ren;
        logic               dmem_wen;
        reg_idx_t           rX;
        reg_idx_t           rY;
        reg_idx_t           rO;
        word_t              vX;
        word_t              vY;
        word_t              imm16;
    } id_ex_t;

endpackage

`default_nettype wire

// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ALU  = 4'd1,
        OP_ADDI = 4'd2,
        OP_LW   = 4'd3,
        OP_SW   = 4'd4,
        OP_BR   = 4'd5,
        OP_JR   = 4'd6,
        OP_HALT = 4'd7
    } opcode_t;

    // three register operands, used by OP_ALU
    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] rO;
        logic [2:0] rX;
        logic [2:0] rY;
        logic [2:0] func;
    } reg_fmt_t;

    // every other opcode, imm6 is sign-extended
    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] rO;
        logic [2:0] rX;
        logic [5:0] imm6;
    } imm_fmt_t;

    typedef union packed {
        reg_fmt_t reg_fmt;
        imm_fmt_t imm_fmt;
    } instr_t;

    typedef enum logic [1:0] {
        FLOW_BASIC   = 2'd0,
        FLOW_BRANCH  = 2'd1,
        FLOW_JUMPREG = 2'd2
    } flow_ty_t;

    // condition lives in the rO field of OP_BR
    typedef enum logic [2:0] {
        FCU_ALWAYS  = 3'd0,
        FCU_ZERO    = 3'd1,
        FCU_NONZERO = 3'd2
    } fcu_op_t;

endpackage

`default_nettype wire
